//--- logic/rs_pkg.sv
// widths are fixed here; tag zero always means the value is present, and arithmetic wraps at data_w bits
package rs_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // operand and result width
    localparam int data_w = 32;

    // reorder buffer tag
    // zero is reserved for no producer
    localparam int tag_w = 5;

    // execute cycles for op_mul
    localparam int mul_latency = 3;

    //////////////////////////////
    // opcodes
    //////////////////////////////

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_mul = 3'd5
    } alu_op_t;

    //////////////////////////////
    // packets
    //////////////////////////////

    // one source operand of 38 bits
    // with ready set the value holds the operand and the tag is only a label
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
        logic              ready;
    } operand_t;

    // decoded instruction from the dispatcher in 84 bits
    typedef struct packed {
        alu_op_t           op;
        logic [tag_w-1:0]  dest_tag;
        operand_t          src_a;
        operand_t          src_b;
    } dispatch_t;

    // station to unit with both operands resolved in 72 bits
    typedef struct packed {
        alu_op_t           op;
        logic [tag_w-1:0]  dest_tag;
        logic [data_w-1:0] value_a;
        logic [data_w-1:0] value_b;
    } issue_t;

    // common data bus word of 38 bits
    // units leave valid to the arbiter register
    typedef struct packed {
        logic              valid;
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
    } cdb_t;

    //////////////////////////////
    // result rule
    //////////////////////////////

    // units compute their results with this
    // add, sub and mul wrap to the low data_w bits
    function automatic logic [data_w-1:0] alu_result(
        alu_op_t           op,
        logic [data_w-1:0] a,
        logic [data_w-1:0] b
    );
        logic [data_w-1:0] res;
        case (op)
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_mul:  res = a * b;
            default: res = '0;
        endcase
        return res;
    endfunction

endpackage

//--- logic/rs_station.sv
// one dispatch per cycle, dropped while full; operands wake only from the registered cdb word
`timescale 1ns/100ps

module rs_station import rs_pkg::*; #(
    parameter int num_entries = 4,
    parameter int num_units   = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  logic                     dispatch,
    input  dispatch_t                dispatch_pkt,
    input  cdb_t                     cdb,
    input  logic   [num_units-1:0]   unit_busy,
    output logic   [num_units-1:0]   issue_valid,
    output issue_t [num_units-1:0]   issue_pkt,
    output logic                     full
);

    // one station slot without its busy bit
    typedef struct packed {
        alu_op_t           op;
        logic [tag_w-1:0]  dest_tag;
        operand_t          src_a;
        operand_t          src_b;
    } rs_entry_t;

    rs_entry_t [num_entries-1:0] entry;
    rs_entry_t [num_entries-1:0] entry_next;

    // occupancy of each slot
    logic [num_entries-1:0] busy;
    logic [num_entries-1:0] busy_next;

    // both operands present
    logic [num_entries-1:0] ready;
    // leaving for a unit this cycle
    logic [num_entries-1:0] issued;

    // one bit per tag still awaited by some slot
    logic [2**tag_w-1:0] waiting_tags;

    // snoop one operand against the bus
    function automatic operand_t capture(operand_t opnd, cdb_t bus);
        operand_t res;
        res = opnd;
        if (bus.valid && !opnd.ready && (opnd.tag == bus.tag)) begin
            res.value = bus.value;
            res.ready = 1'b1;
        end
        return res;
    endfunction

    assign full = &busy;

    always_comb begin
        for (int e = 0; e < num_entries; e++) begin
            ready[e] = busy[e] && entry[e].src_a.ready && entry[e].src_b.ready;
        end
    end

    //////////////////////////////
    // issue select
    //////////////////////////////

    // units in ascending order each take the lowest ready slot left
    always_comb begin : issue_scan
        logic [num_entries-1:0] avail;
        logic                   picked;
        avail       = ready;
        issued      = '0;
        issue_valid = '0;
        for (int u = 0; u < num_units; u++) begin
            picked       = 1'b0;
            issue_pkt[u] = '0;
            if (!unit_busy[u]) begin
                for (int e = 0; e < num_entries; e++) begin
                    if (avail[e] && !picked) begin
                        picked               = 1'b1;
                        avail[e]             = 1'b0;
                        issued[e]            = 1'b1;
                        issue_valid[u]       = 1'b1;
                        issue_pkt[u].op       = entry[e].op;
                        issue_pkt[u].dest_tag = entry[e].dest_tag;
                        issue_pkt[u].value_a  = entry[e].src_a.value;
                        issue_pkt[u].value_b  = entry[e].src_b.value;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // wakeup and dispatch
    //////////////////////////////

    always_comb begin : next_state
        logic placed;
        entry_next = entry;
        // slot frees at the issue edge
        busy_next  = busy & ~issued;
        placed     = 1'b0;

        // broadcast lands in waiting slots
        for (int e = 0; e < num_entries; e++) begin
            entry_next[e].src_a = capture(entry[e].src_a, cdb);
            entry_next[e].src_b = capture(entry[e].src_b, cdb);
        end

        // lowest free slot takes the new instruction
        // its sources snoop the same broadcast so a same-edge wakeup survives
        if (dispatch && !full) begin
            for (int e = 0; e < num_entries; e++) begin
                if (!busy[e] && !placed) begin
                    placed                 = 1'b1;
                    busy_next[e]           = 1'b1;
                    entry_next[e].op       = dispatch_pkt.op;
                    entry_next[e].dest_tag = dispatch_pkt.dest_tag;
                    entry_next[e].src_a    = capture(dispatch_pkt.src_a, cdb);
                    entry_next[e].src_b    = capture(dispatch_pkt.src_b, cdb);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    // slot contents
    always_ff @(posedge clock) begin
        entry <= entry_next;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    always_comb begin
        waiting_tags = '0;
        for (int e = 0; e < num_entries; e++) begin
            if (busy[e] && !entry[e].src_a.ready) begin
                waiting_tags[entry[e].src_a.tag] = 1'b1;
            end
            if (busy[e] && !entry[e].src_b.ready) begin
                waiting_tags[entry[e].src_b.tag] = 1'b1;
            end
        end
    end

    // a broadcast tag is never still awaited one cycle later
    a_no_stale_wait: assert property (
        @(posedge clock) disable iff (reset || squash)
        cdb.valid |=> !waiting_tags[$past(cdb.tag)]
    ) else $error("rs_station: operand still waits on broadcast tag %0d", $past(cdb.tag));

    // dispatcher must respect full
    a_no_dispatch_full: assert property (
        @(posedge clock) disable iff (reset)
        dispatch |-> !full
    ) else $error("rs_station: dispatch while full");

endmodule

//--- logic/fu_alu.sv
// accepts an issue only while idle; result stays on its outputs until the arbiter grants it
`timescale 1ns/100ps

module fu_alu import rs_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   squash,
    input  logic   issue_valid,
    input  issue_t issue_pkt,
    input  logic   grant,
    output logic   unit_busy,
    output logic   done,
    output cdb_t   result
);

    // enough bits to count down mul_latency-1
    localparam int cnt_w = (mul_latency > 2) ? $clog2(mul_latency) : 1;

    // cycles left before done rises
    logic [cnt_w-1:0] count;

    // latched instruction and finished value
    issue_t           held;
    logic [data_w-1:0] value_q;

    logic accept;
    logic finish;

    assign accept = issue_valid && !unit_busy;
    assign finish = unit_busy && !done && (count == '0);

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            // squash drops whatever is in flight
            unit_busy <= 1'b0;
            done      <= 1'b0;
            count     <= '0;
        end else if (grant) begin
            // result leaves on the cdb next cycle
            unit_busy <= 1'b0;
            done      <= 1'b0;
        end else if (accept) begin
            unit_busy <= 1'b1;
            // single-cycle ops finish at the next edge
            count     <= (issue_pkt.op == op_mul) ? cnt_w'(mul_latency - 1) : '0;
        end else if (finish) begin
            done <= 1'b1;
        end else if (unit_busy && !done) begin
            count <= count - 1'b1;
        end
    end

    //////////////////////////////
    // datapath
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (accept) begin
            held <= issue_pkt;
        end
        if (finish) begin
            value_q <= alu_result(held.op, held.value_a, held.value_b);
        end
    end

    // valid here only mirrors done, the arbiter sets the bus bit
    assign result.valid = done;
    assign result.tag   = held.dest_tag;
    assign result.value = value_q;

endmodule

//--- logic/cdb_arbiter.sv
// one broadcast per cycle; the search starts after the last winner, at unit 0 after reset or squash
`timescale 1ns/100ps

module cdb_arbiter import rs_pkg::*; #(
    parameter int num_units = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   squash,
    input  logic [num_units-1:0]   done,
    input  cdb_t [num_units-1:0]   result,
    output logic [num_units-1:0]   grant,
    output cdb_t                   cdb
);

    localparam int ptr_w = (num_units > 1) ? $clog2(num_units) : 1;

    // first unit looked at this cycle
    logic [ptr_w-1:0] start;
    logic [ptr_w-1:0] winner;

    // bus register fields
    logic              cdb_valid;
    logic [tag_w-1:0]  cdb_tag;
    logic [data_w-1:0] cdb_value;

    //////////////////////////////
    // round robin
    //////////////////////////////

    always_comb begin : rr_scan
        int   idx;
        logic found;
        grant  = '0;
        winner = start;
        found  = 1'b0;
        for (int i = 0; i < num_units; i++) begin
            idx = (int'(start) + i) % num_units;
            if (done[idx] && !found) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                winner     = ptr_w'(idx);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            start     <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= |grant;
            // wrap past the last unit
            if (|grant) begin
                start <= (winner == ptr_w'(num_units - 1)) ? '0 : winner + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (|grant) begin
            cdb_tag   <= result[winner].tag;
            cdb_value <= result[winner].value;
        end
    end

    assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

    //////////////////////////////
    // checks
    //////////////////////////////

    a_grant_onehot: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(grant) && ((grant & ~done) == '0)
    ) else $error("cdb_arbiter: bad grant %b for done %b", grant, done);

    // a losing unit must keep its result for the next round
    for (genvar u = 0; u < num_units; u++) begin : g_hold
        a_done_held: assert property (
            @(posedge clock) disable iff (reset || squash)
            (done[u] && !grant[u]) |=> done[u]
        ) else $error("cdb_arbiter: unit %0d dropped an ungranted result", u);
    end

endmodule

//--- logic/rs_top.sv
// the caller holds dispatch low while full is high; cdb is both the output and the wakeup bus
`timescale 1ns/100ps

module rs_top import rs_pkg::*; #(
    parameter int num_entries = 4,
    parameter int num_units   = 2
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,
    input  logic      dispatch,
    input  dispatch_t dispatch_pkt,
    output logic      full,
    output cdb_t      cdb
);

    //////////////////////////////
    // station to units
    //////////////////////////////

    logic   [num_units-1:0] unit_busy;
    logic   [num_units-1:0] issue_valid;
    issue_t [num_units-1:0] issue_pkt;

    //////////////////////////////
    // units to arbiter
    //////////////////////////////

    logic [num_units-1:0] done;
    logic [num_units-1:0] grant;
    cdb_t [num_units-1:0] result;

    rs_station #(
        .num_entries (num_entries),
        .num_units   (num_units)
    ) u_station (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .dispatch     (dispatch),
        .dispatch_pkt (dispatch_pkt),
        .cdb          (cdb),
        .unit_busy    (unit_busy),
        .issue_valid  (issue_valid),
        .issue_pkt    (issue_pkt),
        .full         (full)
    );

    // identical peers, unit 0 wins issue ties
    for (genvar u = 0; u < num_units; u++) begin : g_unit
        fu_alu u_alu (
            .clock       (clock),
            .reset       (reset),
            .squash      (squash),
            .issue_valid (issue_valid[u]),
            .issue_pkt   (issue_pkt[u]),
            .grant       (grant[u]),
            .unit_busy   (unit_busy[u]),
            .done        (done[u]),
            .result      (result[u])
        );
    end

    // registered bus, feeds the output and the station wakeup
    cdb_arbiter #(
        .num_units (num_units)
    ) u_arbiter (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .done   (done),
        .result (result),
        .grant  (grant),
        .cdb    (cdb)
    );

endmodule

//--- test/rs_tb.sv
// runs from the project root and reads test/rs_input.txt; dest tags are unique per run, 1f never produced
`timescale 1ns/100ps

module rs_tb import rs_pkg::*; ();

    localparam int drive_delay = 1;
    localparam int wait_limit  = 200;
    localparam int num_tags    = 2**tag_w;

    logic      clock;
    logic      reset;
    logic      squash;
    logic      dispatch;
    dispatch_t dispatch_pkt;
    logic      full;
    cdb_t      cdb;

    // per tag: value from the data file, still owed, already broadcast
    logic [data_w-1:0] expect_val [num_tags];
    bit                pending    [num_tags];
    bit                seen       [num_tags];

    int              fd;
    bit              aborted;
    int              test_errors;
    int              total_errors;
    int              tests_run;
    int              tests_failed;
    int              broadcasts;
    logic [8*32-1:0] test_name;

    rs_top #(
        .num_entries (4),
        .num_units   (2)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .dispatch     (dispatch),
        .dispatch_pkt (dispatch_pkt),
        .full         (full),
        .cdb          (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////
    // cdb monitor
    //////////////////////////////

    // mid-cycle sample, bus is registered so it is stable here
    always @(negedge clock) begin
        if (!reset && cdb.valid) begin
            broadcasts++;
            if (pending[cdb.tag]) begin
                if (cdb.value !== expect_val[cdb.tag]) begin
                    $display("[FAIL] t=%0t cdb.value (tag %0d): got %h expected %h",
                             $time, cdb.tag, cdb.value, expect_val[cdb.tag]);
                    test_errors++;
                end
                pending[cdb.tag] = 1'b0;
                seen[cdb.tag]    = 1'b1;
            end else if (seen[cdb.tag]) begin
                $display("error at %0t: tag %0d was broadcast a second time", $time, cdb.tag);
                test_errors++;
            end else begin
                $display("error at %0t: broadcast of unknown tag %0d", $time, cdb.tag);
                test_errors++;
            end
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #(drive_delay);
    endtask

    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[FAIL] t=%0t %0s: got %b expected %b", $time, name, got, want);
            test_errors++;
        end
    endtask

    function automatic bit any_pending();
        bit res;
        res = 1'b0;
        for (int t = 0; t < num_tags; t++) begin
            res = res | pending[t];
        end
        return res;
    endfunction

    // a known tag goes out as a ready value, like a real dispatcher
    function automatic operand_t make_source(logic [8*8-1:0] kind, logic [data_w-1:0] field);
        operand_t src;
        src = '0;
        if (kind == "t") begin
            src.tag = field[tag_w-1:0];
            if (seen[src.tag]) begin
                src.value = expect_val[src.tag];
                src.ready = 1'b1;
            end
        end else begin
            src.value = field;
            src.ready = 1'b1;
        end
        return src;
    endfunction

    task automatic finish_test();
        if (tests_run > 0) begin
            if (test_errors == 0) begin
                $display("test %0s: ok", test_name);
            end else begin
                $display("test %0s: %0d errors", test_name, test_errors);
                tests_failed++;
            end
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic run_dispatch(input logic [8*160-1:0] line);
        logic [8*8-1:0]    cmd;
        logic [8*8-1:0]    op_word;
        logic [8*8-1:0]    kind_a;
        logic [8*8-1:0]    kind_b;
        logic [31:0]       dest;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] want;
        alu_op_t           op;
        int                waited;
        if ($sscanf(line, "%s %s %h %s %h %s %h %h",
                    cmd, op_word, dest, kind_a, a, kind_b, b, want) != 8) begin
            $display("error: malformed dispatch line in the data file");
            test_errors++;
            return;
        end
        case (op_word)
            "add": op = op_add;
            "sub": op = op_sub;
            "and": op = op_and;
            "or":  op = op_or;
            "xor": op = op_xor;
            "mul": op = op_mul;
            default: begin
                $display("error: unknown opcode in the data file");
                test_errors++;
                return;
            end
        endcase
        if (dest[tag_w-1:0] == 0 || pending[dest[tag_w-1:0]] || seen[dest[tag_w-1:0]]) begin
            $display("error: dest tag %0d is zero or used twice in the data file", dest);
            test_errors++;
            return;
        end
        // back-pressure, hold off while the station is full
        waited = 0;
        while (full && !aborted) begin
            if (waited == wait_limit) begin
                $display("error at %0t: full never dropped for tag %0d", $time, dest);
                test_errors++;
                aborted = 1'b1;
            end else begin
                next_cycle();
                waited++;
            end
        end
        if (!aborted) begin
            dispatch_pkt.op       = op;
            dispatch_pkt.dest_tag = dest[tag_w-1:0];
            dispatch_pkt.src_a    = make_source(kind_a, a);
            dispatch_pkt.src_b    = make_source(kind_b, b);
            expect_val[dest[tag_w-1:0]] = want;
            pending[dest[tag_w-1:0]]    = 1'b1;
            dispatch = 1'b1;
            next_cycle();
            dispatch = 1'b0;
        end
    endtask

    // stop in the cycle the tag is on the bus, so the next dispatch races it
    task automatic wait_tag(input logic [tag_w-1:0] tag);
        int waited;
        waited = 0;
        while (!(cdb.valid && cdb.tag == tag) && !aborted) begin
            if (waited == wait_limit) begin
                $display("error at %0t: tag %0d never appeared on the cdb", $time, tag);
                test_errors++;
                aborted = 1'b1;
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic drain_tags();
        int waited;
        waited = 0;
        while (any_pending() && !aborted) begin
            if (waited == wait_limit) begin
                for (int t = 0; t < num_tags; t++) begin
                    if (pending[t]) begin
                        $display("error at %0t: tag %0d still missing at timeout", $time, t);
                        test_errors++;
                    end
                end
                aborted = 1'b1;
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    // squashed tags must never show up later
    task automatic run_squash();
        squash = 1'b1;
        next_cycle();
        squash = 1'b0;
        for (int t = 0; t < num_tags; t++) begin
            pending[t] = 1'b0;
        end
    endtask

    //////////////////////////////
    // command loop
    //////////////////////////////

    initial begin : main
        logic [8*160-1:0] line;
        logic [8*8-1:0]   cmd;
        logic [8*32-1:0]  name;
        logic [31:0]      arg;
        reset        = 1'b1;
        squash       = 1'b0;
        dispatch     = 1'b0;
        dispatch_pkt = '0;
        aborted      = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        broadcasts   = 0;
        for (int t = 0; t < num_tags; t++) begin
            expect_val[t] = '0;
            pending[t]    = 1'b0;
            seen[t]       = 1'b0;
        end
        fd = $fopen("test/rs_input.txt", "r");
        repeat (3) @(posedge clock);
        #(drive_delay);
        reset = 1'b0;
        if (fd == 0) begin
            $display("error: cannot open test/rs_input.txt");
            total_errors++;
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0 && $sscanf(line, "%s", cmd) == 1) begin
                if (cmd == "T") begin
                    void'($sscanf(line, "%s %s", cmd, name));
                    finish_test();
                    test_name = name;
                    tests_run++;
                end else if (cmd == "D") begin
                    run_dispatch(line);
                end else if (cmd == "W") begin
                    void'($sscanf(line, "%s %h", cmd, arg));
                    wait_tag(arg[tag_w-1:0]);
                end else if (cmd == "F") begin
                    void'($sscanf(line, "%s %h", cmd, arg));
                    check_level("full", full, arg[0]);
                end else if (cmd == "V") begin
                    void'($sscanf(line, "%s %h", cmd, arg));
                    check_level("cdb.valid", cdb.valid, arg[0]);
                end else if (cmd == "S") begin
                    run_squash();
                end else if (cmd == "I") begin
                    void'($sscanf(line, "%s %h", cmd, arg));
                    repeat (arg) next_cycle();
                end else if (cmd == "E") begin
                    drain_tags();
                end else if (cmd != "#") begin
                    $display("error: unknown command in the data file");
                    test_errors++;
                end
            end
        end
        finish_test();
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("summary: %0d tests, %0d failed, %0d broadcasts, %0d errors",
                 tests_run, tests_failed, broadcasts, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- test/rs_input.txt
# T name | D op dest (v value | t tag) (v value | t tag) expected | W tag | F full | V cdb_valid
# S squash one cycle | I idle cycles | E wait for every owed tag; all numbers are hex
T reset
F 0
V 0
I 4
E
T independent
D add 1 v 12345678 v 11111111 23456789
D sub 2 v 5 v 7 fffffffe
D and 3 v f0f0f0f0 v 3c3c3c3c 30303030
D or 4 v 0f00ff00 v 00f000ff 0ff0ffff
D xor 5 v aaaaaaaa v 5555ffff ffff5555
D mul 6 v 00010001 v 00010001 00020001
E
T chain
D add 7 v a v 14 1e
D mul 8 t 7 v 3 5a
D sub 9 t 8 t 7 3c
D add a v 1 v 2 3
W a
D xor b t a v ff fc
D mul c t b t 9 3b10
E
T squash
D add d t 1f v 1 0
D sub e t 1f v 2 0
D mul f v 3 t 1f 0
D and 10 t 1f t 1f 0
F 1
S
F 0
I a
D or 11 v 1 v 2 3
E
T contention
D mul 12 v 7 v 6 2a
D mul 13 v 100 v 100 10000
D add 14 v ffffffff v 2 1
D sub 15 v 0 v 1 ffffffff
D mul 16 v 12345 v 10 123450
D xor 17 v 1 v 3 2
D and 18 v ff v f f
D or 19 v 100 v 1 101
E

//--- files.f
logic/rs_pkg.sv
logic/rs_station.sv
logic/fu_alu.sv
logic/cdb_arbiter.sv
logic/rs_top.sv
test/rs_tb.sv

//--- Bender.yml
package:
  name: rs_slice

sources:
  - files:
      - logic/rs_pkg.sv
      - logic/rs_station.sv
      - logic/fu_alu.sv
      - logic/cdb_arbiter.sv
      - logic/rs_top.sv
  - target: test
    files:
      - test/rs_tb.sv
